//--- common/panel_pkg.sv
package panel_pkg;

	// function key index, matches the host command encoding
	typedef enum logic [3:0] {
		fn_start = 4'd0,
		fn_mode  = 4'd1,
		fn_clock = 4'd2,
		fn_stopn = 4'd3,
		fn_step  = 4'd4,
		fn_fetch = 4'd5,
		fn_store = 4'd6,
		fn_cycle = 4'd7,
		fn_load  = 4'd8,
		fn_bin   = 4'd9,
		fn_oprq  = 4'd10,
		fn_clear = 4'd11
	} fn_key_t;

	typedef logic [11:0] fn_keys_t;

	// stopn through clear fall back after the hold time
	localparam fn_keys_t fn_momentary_mask = 12'b1111_1111_1000;

	// {wre, rsc, rsb, rsa, ic, ac, ar, ir, rs, rz, kb}
	typedef logic [10:0] rotary_t;

	localparam rotary_t rotary_codes [15] = '{
		11'b100_0000_0000, 11'b100_1000_0000, 11'b101_0000_0000, 11'b101_1000_0000,
		11'b110_0000_0000, 11'b110_1000_0000, 11'b111_0000_0000, 11'b111_1000_0000,
		11'b000_0100_0000, 11'b000_0010_0000, 11'b000_0001_0000, 11'b000_0000_1000,
		11'b000_0000_0100, 11'b000_0000_0010, 11'b000_0000_0001
	};

	localparam rotary_t rotary_reset = 11'b100_1000_0000;

	// top three bits of a command byte
	typedef enum logic [2:0] {
		cmd_none        = 3'd0,
		cmd_fnkey       = 3'd1,
		cmd_keys_lo     = 3'd2,
		cmd_keys_lo_alt = 3'd3,
		cmd_keys_mid    = 3'd4,
		cmd_keys_hi     = 3'd5,
		cmd_leds        = 3'd6,
		cmd_rotary      = 3'd7
	} cmd_class_t;

	// active low, bit 0 is segment a, bit 7 the dot
	localparam logic [7:0] seg_hex [16] = '{
		8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
		8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e
	};

	localparam logic [7:0] seg_blank = 8'hff;

endpackage

//--- common/panel_ctl_if.sv
interface panel_ctl_if;
	import panel_pkg::*;

	logic [15:0] keys;
	fn_keys_t fn;
	rotary_t rotary;
	// one cycle, whenever any field changed
	logic update;

	modport decoder (
		output keys,
		output fn,
		output rotary,
		output update
	);

	modport panel (
		input keys,
		input fn,
		input rotary,
		input update
	);

endinterface

//--- uart/uart_rx.sv
module uart_rx #(
	parameter int CLK_PER_BIT = 16
) (
	input  logic       CLK_EXT,
	input  logic       rst,
	input  logic       rxd,
	output logic [7:0] rx_data,
	output logic       rx_valid
);

	localparam int CNT_W = (CLK_PER_BIT > 2) ? $clog2(CLK_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_PER_BIT - 1);
	localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLK_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} state_t;

	state_t state;
	logic [1:0] rxd_sync;
	logic rxd_s;
	logic [CNT_W-1:0] smp_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shift;

	// line idles high
	always_ff @(posedge CLK_EXT) begin
		if (rst) begin
			rxd_sync <= 2'b11;
		end else begin
			rxd_sync <= {rxd_sync[0], rxd};
		end
	end

	assign rxd_s = rxd_sync[1];

	always_ff @(posedge CLK_EXT) begin
		if (rst) begin
			state <= st_idle;
			smp_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
			st_idle: begin
				smp_cnt <= '0;
				if (!rxd_s) begin
					state <= st_start;
				end
			end
			st_start: begin
				if (smp_cnt == CNT_HALF) begin
					smp_cnt <= '0;
					bit_cnt <= '0;
					// start bit gone high again, treat as a glitch
					state <= rxd_s ? st_idle : st_data;
				end else begin
					smp_cnt <= smp_cnt + 1'b1;
				end
			end
			st_data: begin
				if (smp_cnt == CNT_LAST) begin
					smp_cnt <= '0;
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7) begin
						state <= st_stop;
					end
				end else begin
					smp_cnt <= smp_cnt + 1'b1;
				end
			end
			st_stop: begin
				if (smp_cnt == CNT_LAST) begin
					// framing error drops the byte
					rx_valid <= rxd_s;
					state <= st_idle;
				end else begin
					smp_cnt <= smp_cnt + 1'b1;
				end
			end
			default: state <= st_idle;
			endcase
		end
	end

	// lsb first
	always_ff @(posedge CLK_EXT) begin
		if (state == st_data && smp_cnt == CNT_LAST) begin
			shift <= {rxd_s, shift[7:1]};
		end
	end

	assign rx_data = shift;

endmodule

//--- hw/panel_cmd_decoder.sv
module panel_cmd_decoder #(
	parameter int HOLD_CYCLES = 1_000_000
) (
	input logic                CLK_EXT,
	input logic                rst,
	input logic [7:0]          rx_data,
	input logic                rx_valid,
	panel_ctl_if.decoder       ctl
);
	import panel_pkg::*;

	localparam int HOLD_W = $clog2(HOLD_CYCLES + 1);
	localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(HOLD_CYCLES);

	cmd_class_t cls;
	logic [3:0] key_idx;
	logic [3:0] rot_pos;
	logic [15:0] keys_q;
	logic [15:0] keys_nx;
	fn_keys_t fn_q;
	fn_keys_t fn_nx;
	rotary_t rot_q;
	rotary_t rot_nx;
	logic [HOLD_W-1:0] hold_cnt;
	logic hold_expire;
	logic update_q;

	assign cls = cmd_class_t'(rx_data[7:5]);
	assign key_idx = rx_data[4:1];
	assign rot_pos = rx_data[3:0];
	assign hold_expire = (hold_cnt == HOLD_W'(1));

	always_comb begin
		keys_nx = keys_q;
		fn_nx = fn_q;
		rot_nx = rot_q;
		if (rx_valid) begin
			case (cls)
			cmd_fnkey: begin
				if (key_idx <= 4'(fn_clear)) begin
					fn_nx[key_idx] = rx_data[0];
				end
			end
			cmd_keys_lo, cmd_keys_lo_alt: keys_nx[5:0] = rx_data[5:0];
			cmd_keys_mid: keys_nx[10:6] = rx_data[4:0];
			cmd_keys_hi: keys_nx[15:11] = rx_data[4:0];
			cmd_rotary: begin
				// position 15 has no switch stop
				if (rot_pos != 4'hf) begin
					rot_nx = rotary_codes[rot_pos];
				end
			end
			default: ;
			endcase
		end else if (hold_expire) begin
			fn_nx = fn_q & ~fn_momentary_mask;
		end
	end

	always_ff @(posedge CLK_EXT) begin
		if (rst) begin
			keys_q <= '0;
			fn_q <= '0;
			rot_q <= rotary_reset;
			update_q <= 1'b0;
			hold_cnt <= '0;
		end else begin
			keys_q <= keys_nx;
			fn_q <= fn_nx;
			rot_q <= rot_nx;
			update_q <= {keys_nx, fn_nx, rot_nx} != {keys_q, fn_q, rot_q};
			// every byte restarts the hold window
			if (rx_valid) begin
				hold_cnt <= HOLD_LOAD;
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
		end
	end

	assign ctl.keys = keys_q;
	assign ctl.fn = fn_q;
	assign ctl.rotary = rot_q;
	assign ctl.update = update_q;

endmodule

//--- hw/panel_signals.sv
module panel_signals #(
	parameter int TICK_DIV = 50_000,
	parameter int TIMER_CYCLE_MS = 10
) (
	input  logic        CLK_EXT,
	input  logic        rst,
	panel_ctl_if.panel  ctl,
	input  logic        hlt_n,
	input  logic        p0_n,
	output logic        work,
	output logic        mode,
	output logic        clock_en,
	output logic        start_pulse_n,
	output logic        stop_pulse_n,
	output logic        stop_n,
	output logic [15:0] kl,
	output logic        clear_n,
	output logic        step_n,
	output logic        fetch_n,
	output logic        store_n,
	output logic        cycle_n,
	output logic        load_n,
	output logic        bin_n,
	output logic        oprq_n,
	output logic        timer_n,
	output logic        wre_n,
	output logic        rsa,
	output logic        rsb,
	output logic        rsc,
	output logic        wic,
	output logic        wac,
	output logic        war,
	output logic        wir,
	output logic        wrs,
	output logic        wrz,
	output logic        wkb
);
	import panel_pkg::*;

	localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
	localparam int MS_W = (TIMER_CYCLE_MS > 1) ? $clog2(TIMER_CYCLE_MS) : 1;

	logic start_q;
	logic stopn_q;
	logic [PRE_W-1:0] pre_cnt;
	logic tick;
	logic [MS_W-1:0] ms_cnt;

	assign work = ctl.fn[fn_start];
	assign mode = ctl.fn[fn_mode];
	assign clock_en = ctl.fn[fn_clock];
	assign kl = ctl.keys;

	// start key edges, plus the stop-on-address toggle
	always_ff @(posedge CLK_EXT) begin
		if (rst) begin
			start_q <= 1'b0;
			stopn_q <= 1'b0;
			start_pulse_n <= 1'b1;
			stop_pulse_n <= 1'b1;
			stop_n <= 1'b0;
		end else begin
			start_q <= ctl.fn[fn_start];
			stopn_q <= ctl.fn[fn_stopn];
			start_pulse_n <= ~(ctl.fn[fn_start] & ~start_q);
			stop_pulse_n <= ~(~ctl.fn[fn_start] & start_q);
			if (!hlt_n) begin
				stop_n <= 1'b0;
			end else if (ctl.update && ctl.fn[fn_stopn] && !stopn_q) begin
				stop_n <= ~stop_n;
			end
		end
	end

	assign clear_n = ~ctl.fn[fn_clear];
	assign step_n = ~ctl.fn[fn_step];
	assign oprq_n = ~ctl.fn[fn_oprq];
	// memory strobes only during p0
	assign fetch_n = ~(ctl.fn[fn_fetch] & ~p0_n);
	assign store_n = ~(ctl.fn[fn_store] & ~p0_n);
	assign cycle_n = ~(ctl.fn[fn_cycle] & ~p0_n);
	assign load_n = ~(ctl.fn[fn_load] & ~p0_n);
	assign bin_n = ~(ctl.fn[fn_bin] & ~p0_n);

	assign {wre_n, rsc, rsb, rsa, wic, wac, war, wir, wrs, wrz, wkb} = ctl.rotary;

	// ms tick prescaler and interval counter
	always_ff @(posedge CLK_EXT) begin
		if (rst) begin
			pre_cnt <= '0;
			ms_cnt <= '0;
		end else begin
			pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
			if (tick) begin
				ms_cnt <= (ms_cnt == '0) ? MS_W'(TIMER_CYCLE_MS - 1) : ms_cnt - 1'b1;
			end
		end
	end

	assign tick = (pre_cnt == PRE_W'(TICK_DIV - 1));
	assign timer_n = (ms_cnt != '0) & ctl.fn[fn_clock];

endmodule

//--- display/seg_display.sv
module seg_display #(
	parameter int SCAN_DIV = 50_000
) (
	input  logic               CLK_EXT,
	input  logic               rst,
	input  logic [15:0]        w,
	input  panel_pkg::rotary_t rotary,
	input  logic               p_n,
	input  logic               mc_n,
	input  logic               alarm_n,
	input  logic               wait_n,
	input  logic               irq,
	input  logic               q,
	input  logic               run,
	input  logic               mode,
	input  logic               stop_n,
	input  logic               clock_en,
	output logic [7:0]         seg,
	output logic [7:0]         dig
);
	import panel_pkg::*;

	localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic [2:0] scan_idx;
	logic [7:0] dots;
	logic [7:0] pat;
	logic [2:0] reg_num;

	always_ff @(posedge CLK_EXT) begin
		if (rst) begin
			div_cnt <= '0;
			scan_idx <= '0;
		end else if (div_cnt == DIV_W'(SCAN_DIV - 1)) begin
			div_cnt <= '0;
			scan_idx <= scan_idx + 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// general registers carry their number, special ones are one-hot
	always_comb begin
		reg_num = rotary[9:7];
		if (!rotary[10]) begin
			for (int i = 0; i < 7; i++) begin
				if (rotary[i]) begin
					reg_num = 3'(6 - i);
				end
			end
		end
	end

	// digit 7 is run, digit 0 is q
	assign dots = {run, ~wait_n, ~alarm_n, irq, mode, stop_n, clock_en, q};

	always_comb begin
		case (scan_idx)
		3'd0, 3'd1, 3'd2, 3'd3: pat = seg_hex[w[{scan_idx[1:0], 2'b00} +: 4]];
		3'd4: pat = seg_blank;
		// group 0 general, 1 special
		3'd5: pat = seg_hex[{3'b000, ~rotary[10]}];
		3'd6: pat = seg_hex[{1'b0, reg_num}];
		default: pat = {1'b1, mc_n, 5'b11111, p_n};
		endcase
	end

	assign seg = {~dots[scan_idx], pat[6:0]};
	assign dig = ~(8'b0000_0001 << scan_idx);

endmodule

//--- hw/panel_top.sv
module panel_top #(
	parameter int CLK_PER_BIT = 50,
	parameter int HOLD_CYCLES = 1_000_000,
	parameter int TICK_DIV = 50_000,
	parameter int TIMER_CYCLE_MS = 10,
	parameter int SCAN_DIV = 50_000
) (
	input  logic        CLK_EXT,
	input  logic        rst,
	input  logic        RXD,
	input  logic        hlt_n,
	input  logic        p0_n,
	input  logic [15:0] w,
	input  logic        p_n,
	input  logic        mc_n,
	input  logic        alarm_n,
	input  logic        wait_n,
	input  logic        irq,
	input  logic        q,
	input  logic        run,
	output logic        work,
	output logic        mode,
	output logic        clock_en,
	output logic        start_pulse_n,
	output logic        stop_pulse_n,
	output logic        stop_n,
	output logic [15:0] kl,
	output logic        clear_n,
	output logic        step_n,
	output logic        fetch_n,
	output logic        store_n,
	output logic        cycle_n,
	output logic        load_n,
	output logic        bin_n,
	output logic        oprq_n,
	output logic        timer_n,
	output logic        wre_n,
	output logic        rsa,
	output logic        rsb,
	output logic        rsc,
	output logic        wic,
	output logic        wac,
	output logic        war,
	output logic        wir,
	output logic        wrs,
	output logic        wrz,
	output logic        wkb,
	output logic [7:0]  SEG,
	output logic [7:0]  DIG
);
	import panel_pkg::*;

	logic [7:0] rx_data;
	logic rx_valid;

	panel_ctl_if ctl_i ();

	uart_rx #(
		.CLK_PER_BIT(CLK_PER_BIT)
	) uart_i (
		.CLK_EXT(CLK_EXT),
		.rst(rst),
		.rxd(RXD),
		.rx_data(rx_data),
		.rx_valid(rx_valid)
	);

	panel_cmd_decoder #(
		.HOLD_CYCLES(HOLD_CYCLES)
	) dec_i (
		.CLK_EXT(CLK_EXT),
		.rst(rst),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.ctl(ctl_i.decoder)
	);

	panel_signals #(
		.TICK_DIV(TICK_DIV),
		.TIMER_CYCLE_MS(TIMER_CYCLE_MS)
	) sig_i (
		.CLK_EXT(CLK_EXT),
		.rst(rst),
		.ctl(ctl_i.panel),
		.hlt_n(hlt_n),
		.p0_n(p0_n),
		.work(work),
		.mode(mode),
		.clock_en(clock_en),
		.start_pulse_n(start_pulse_n),
		.stop_pulse_n(stop_pulse_n),
		.stop_n(stop_n),
		.kl(kl),
		.clear_n(clear_n),
		.step_n(step_n),
		.fetch_n(fetch_n),
		.store_n(store_n),
		.cycle_n(cycle_n),
		.load_n(load_n),
		.bin_n(bin_n),
		.oprq_n(oprq_n),
		.timer_n(timer_n),
		.wre_n(wre_n),
		.rsa(rsa),
		.rsb(rsb),
		.rsc(rsc),
		.wic(wic),
		.wac(wac),
		.war(war),
		.wir(wir),
		.wrs(wrs),
		.wrz(wrz),
		.wkb(wkb)
	);

	seg_display #(
		.SCAN_DIV(SCAN_DIV)
	) disp_i (
		.CLK_EXT(CLK_EXT),
		.rst(rst),
		.w(w),
		.rotary(ctl_i.rotary),
		.p_n(p_n),
		.mc_n(mc_n),
		.alarm_n(alarm_n),
		.wait_n(wait_n),
		.irq(irq),
		.q(q),
		.run(run),
		.mode(ctl_i.fn[fn_mode]),
		.stop_n(stop_n),
		.clock_en(ctl_i.fn[fn_clock]),
		.seg(SEG),
		.dig(DIG)
	);

endmodule

//--- tests/panel_tb.sv
module panel_tb;
	import panel_pkg::*;

	localparam int CLK_PER_BIT = 8;
	localparam int HOLD_CYCLES = 40;
	localparam int TICK_DIV = 4;
	localparam int TIMER_CYCLE_MS = 5;
	localparam int SCAN_DIV = 2;
	localparam int WAIT_LIMIT = 200;

	logic CLK_EXT;
	logic rst;
	logic RXD;
	logic hlt_n;
	logic p0_n;
	logic [15:0] w;
	logic p_n;
	logic mc_n;
	logic alarm_n;
	logic wait_n;
	logic irq;
	logic q;
	logic run;
	logic work;
	logic mode;
	logic clock_en;
	logic start_pulse_n;
	logic stop_pulse_n;
	logic stop_n;
	logic [15:0] kl;
	logic clear_n;
	logic step_n;
	logic fetch_n;
	logic store_n;
	logic cycle_n;
	logic load_n;
	logic bin_n;
	logic oprq_n;
	logic timer_n;
	logic wre_n;
	logic rsa;
	logic rsb;
	logic rsc;
	logic wic;
	logic wac;
	logic war;
	logic wir;
	logic wrs;
	logic wrz;
	logic wkb;
	logic [7:0] SEG;
	logic [7:0] DIG;
	logic [31:0] lfsr_state;

	panel_top #(
		.CLK_PER_BIT(CLK_PER_BIT),
		.HOLD_CYCLES(HOLD_CYCLES),
		.TICK_DIV(TICK_DIV),
		.TIMER_CYCLE_MS(TIMER_CYCLE_MS),
		.SCAN_DIV(SCAN_DIV)
	) dut_i (.*);

	initial begin
		CLK_EXT = 1'b0;
		forever begin
			#4 CLK_EXT = ~CLK_EXT;
		end
	end

	task automatic stop_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("FAILED %s expected %h actual %h", name, exp, act);
		stop_run();
	endtask

	task automatic fail_now(input string what);
		$display("%s", what);
		stop_run();
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
	endtask

	// lit segments gfedcba, inverted for the active-low pins
	function automatic logic [6:0] hex_segments(input logic [3:0] nib);
		logic [6:0] lit;
		case (nib)
		4'h0: lit = 7'h3f;
		4'h1: lit = 7'h06;
		4'h2: lit = 7'h5b;
		4'h3: lit = 7'h4f;
		4'h4: lit = 7'h66;
		4'h5: lit = 7'h6d;
		4'h6: lit = 7'h7d;
		4'h7: lit = 7'h07;
		4'h8: lit = 7'h7f;
		4'h9: lit = 7'h6f;
		4'ha: lit = 7'h77;
		4'hb: lit = 7'h7c;
		4'hc: lit = 7'h39;
		4'hd: lit = 7'h5e;
		4'he: lit = 7'h79;
		default: lit = 7'h71;
		endcase
		return ~lit;
	endfunction

	function automatic rotary_t rotary_seen();
		return {wre_n, rsc, rsb, rsa, wic, wac, war, wir, wrs, wrz, wkb};
	endfunction

	// key order, active high; stop_n stands in for the stop-on-address slot
	function automatic fn_keys_t strobes_seen();
		return {~clear_n, ~oprq_n, ~bin_n, ~load_n, ~cycle_n, ~store_n, ~fetch_n,
			~step_n, stop_n, clock_en, mode, work};
	endfunction

	function automatic logic read_bit(input string sig);
		if (sig == "work") return work;
		if (sig == "stop_n") return stop_n;
		if (sig == "start_pulse_n") return start_pulse_n;
		if (sig == "stop_pulse_n") return stop_pulse_n;
		if (sig == "fetch_n") return fetch_n;
		if (sig == "timer_n") return timer_n;
		return 1'bx;
	endfunction

	task automatic check_keys(input string name, input logic [15:0] exp);
		int n;
		n = 0;
		while (kl !== exp && n < WAIT_LIMIT) begin
			@(negedge CLK_EXT);
			n++;
		end
		if (kl !== exp) fail_value(name, 32'(exp), 32'(kl));
	endtask

	task automatic check_rotary(input string name, input rotary_t exp);
		int n;
		n = 0;
		while (rotary_seen() !== exp && n < WAIT_LIMIT) begin
			@(negedge CLK_EXT);
			n++;
		end
		if (rotary_seen() !== exp) fail_value(name, 32'(exp), 32'(rotary_seen()));
	endtask

	task automatic check_strobes(input string name, input fn_keys_t exp);
		int n;
		n = 0;
		while (strobes_seen() !== exp && n < WAIT_LIMIT) begin
			@(negedge CLK_EXT);
			n++;
		end
		if (strobes_seen() !== exp) fail_value(name, 32'(exp), 32'(strobes_seen()));
	endtask

	task automatic check_bit(input string name, input string sig, input logic exp);
		int n;
		n = 0;
		while (read_bit(sig) !== exp && n < WAIT_LIMIT) begin
			@(negedge CLK_EXT);
			n++;
		end
		if (read_bit(sig) !== exp) fail_value({name, " ", sig}, 32'(exp), 32'(read_bit(sig)));
	endtask

	task automatic match_count(input string name, input int exp, input int act);
		if (act != exp) fail_value(name, 32'(exp), 32'(act));
	endtask

	task automatic match_seg(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) fail_value(name, 32'(exp), 32'(act));
	endtask

	task automatic expect_steady(input string name, input string sig, input logic val,
			input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge CLK_EXT);
			if (read_bit(sig) !== val) fail_value({name, " ", sig}, 32'(val), 32'(read_bit(sig)));
		end
	endtask

	task automatic count_lows(input string sig, input int cycles, output int n);
		n = 0;
		for (int i = 0; i < cycles; i++) begin
			@(negedge CLK_EXT);
			if (read_bit(sig) == 1'b0) n++;
		end
	endtask

	// 8n1, lsb first, then two idle bit times
	task automatic send_byte(input logic [7:0] b);
		RXD = 1'b0;
		repeat (CLK_PER_BIT) @(negedge CLK_EXT);
		for (int i = 0; i < 8; i++) begin
			RXD = b[i];
			repeat (CLK_PER_BIT) @(negedge CLK_EXT);
		end
		RXD = 1'b1;
		repeat (3 * CLK_PER_BIT) @(negedge CLK_EXT);
	endtask

	task automatic play_golden();
		int fd;
		int rc;
		int lines;
		string text;
		string name;
		logic [7:0] cmd;
		logic [15:0] exp_kl;
		logic [10:0] exp_rot;
		logic [11:0] exp_fn;
		fd = $fopen("tests/panel_golden.txt", "r");
		if (fd == 0) fail_now("cannot open tests/panel_golden.txt");
		lines = 0;
		while (!$feof(fd)) begin
			rc = $fgets(text, fd);
			if (rc > 0 && text.substr(0, 0) != "#") begin
				rc = $sscanf(text, "%s %h %h %h %h", name, cmd, exp_kl, exp_rot, exp_fn);
				if (rc == 5) begin
					send_byte(cmd);
					check_keys(name, exp_kl);
					check_rotary(name, exp_rot);
					check_strobes(name, exp_fn);
					lines++;
				end
			end
		end
		$fclose(fd);
		if (lines == 0) fail_now("golden file holds no test lines");
	endtask

	// mode, clock and stop_n are all off here, so only digit 0 has a dot
	task automatic scan_display(input logic [15:0] word, input logic dot0);
		int lows;
		int idx;
		logic [3:0] seen;
		logic [7:0] exp_seg;
		w = word;
		q = dot0;
		seen = '0;
		idx = 0;
		for (int c = 0; c < 12 * SCAN_DIV; c++) begin
			@(negedge CLK_EXT);
			lows = 0;
			for (int i = 0; i < 8; i++) begin
				if (!DIG[i]) begin
					lows++;
					idx = i;
				end
			end
			if (lows != 1) fail_now($sformatf("display has %0d digit lines active", lows));
			if (idx < 4) begin
				exp_seg = {(idx == 0) ? ~dot0 : 1'b1, hex_segments(word[idx*4 +: 4])};
				match_seg("display", exp_seg, SEG);
				seen[idx] = 1'b1;
			end
		end
		if (seen != 4'hf) fail_now("a data digit of the display was never selected");
	endtask

	initial begin
		logic [15:0] v;
		logic [15:0] qb;
		int n;
		RXD = 1'b1;
		rst = 1'b1;
		hlt_n = 1'b1;
		p0_n = 1'b0;
		w = '0;
		p_n = 1'b1;
		mc_n = 1'b1;
		alarm_n = 1'b1;
		wait_n = 1'b1;
		irq = 1'b0;
		q = 1'b0;
		run = 1'b0;
		lfsr_state = 32'h302e_9e71;
		repeat (5) @(negedge CLK_EXT);
		rst = 1'b0;

		check_keys("reset", 16'h0000);
		check_rotary("reset", 11'h480);
		check_strobes("reset", 12'h000);
		check_bit("reset", "start_pulse_n", 1'b1);
		check_bit("reset", "stop_pulse_n", 1'b1);
		check_bit("reset", "timer_n", 1'b0);

		play_golden();

		// data keys from the lfsr, split over the three key classes
		for (int r = 0; r < 4; r++) begin
			draw_bits(16, v);
			send_byte({2'b01, v[5:0]});
			send_byte({3'b100, v[10:6]});
			send_byte({3'b101, v[15:11]});
			check_keys("keys_random", v);
		end

		// fetch pressed outside p0, then p0 opens inside the hold window
		p0_n = 1'b1;
		send_byte(8'h2b);
		expect_steady("gated_fetch", "fetch_n", 1'b1, 4);
		check_strobes("gated_fetch", 12'h000);
		p0_n = 1'b0;
		check_bit("fetch_in_p0", "fetch_n", 1'b0);
		check_bit("fetch_release", "fetch_n", 1'b1);

		fork
			send_byte(8'h21);
			count_lows("start_pulse_n", 12 * CLK_PER_BIT, n);
		join
		match_count("start_pulse", 1, n);
		check_bit("start_on", "work", 1'b1);
		fork
			send_byte(8'h20);
			count_lows("stop_pulse_n", 12 * CLK_PER_BIT, n);
		join
		match_count("stop_pulse", 1, n);
		check_bit("start_off", "work", 1'b0);

		send_byte(8'h27);
		check_bit("stop_addr_1", "stop_n", 1'b1);
		send_byte(8'h27);
		check_bit("stop_addr_2", "stop_n", 1'b0);
		send_byte(8'h27);
		check_bit("stop_addr_3", "stop_n", 1'b1);
		hlt_n = 1'b0;
		check_bit("halt_clear", "stop_n", 1'b0);
		hlt_n = 1'b1;
		expect_steady("halt_clear", "stop_n", 1'b0, 8);

		// one low tick period per timer cycle
		send_byte(8'h25);
		count_lows("timer_n", 5 * TICK_DIV * TIMER_CYCLE_MS, n);
		match_count("timer_on", 5 * TICK_DIV, n);
		send_byte(8'h24);
		expect_steady("timer_off", "timer_n", 1'b0, 3 * TICK_DIV * TIMER_CYCLE_MS);

		for (int r = 0; r < 8; r++) begin
			draw_bits(16, v);
			draw_bits(1, qb);
			scan_display(v, qb[0]);
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- tests/panel_golden.txt
# name cmd kl rotary strobes, all hex; rotary = wre_n rsc rsb rsa wic wac war wir wrs wrz wkb
# strobes active high, msb first: clear oprq bin load cycle store fetch step stop_n clock mode work
keys_lo_alt   6a 002a 480 000
keys_mid      95 056a 480 000
keys_hi       b3 9d6a 480 000
none_ignored  1f 9d6a 480 000
leds_ignored  df 9d6a 480 000
keys_lo       45 9d45 480 000
rot_0         e0 9d45 400 000
rot_1         e1 9d45 480 000
rot_2         e2 9d45 500 000
rot_3         e3 9d45 580 000
rot_4         e4 9d45 600 000
rot_5         e5 9d45 680 000
rot_6         e6 9d45 700 000
rot_7         e7 9d45 780 000
rot_8_ic      e8 9d45 040 000
rot_9_ac      e9 9d45 020 000
rot_10_ar     ea 9d45 010 000
rot_11_ir     eb 9d45 008 000
rot_12_rs     ec 9d45 004 000
rot_13_rz     ed 9d45 002 000
rot_14_kb     ee 9d45 001 000
rot_15_none   ef 9d45 001 000
start_on      21 9d45 001 001
mode_on       23 9d45 001 003
clock_on      25 9d45 001 007
step          29 9d45 001 017
fetch         2b 9d45 001 027
store         2d 9d45 001 047
cycle         2f 9d45 001 087
load          31 9d45 001 107
bin           33 9d45 001 207
oprq          35 9d45 001 407
clear         37 9d45 001 807
bad_index     39 9d45 001 007
start_off     20 9d45 001 006
mode_off      22 9d45 001 004
clock_off     24 9d45 001 000

//--- panel.f
common/panel_pkg.sv
common/panel_ctl_if.sv
uart/uart_rx.sv
hw/panel_cmd_decoder.sv
hw/panel_signals.sv
display/seg_display.sv
hw/panel_top.sv
tests/panel_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the panel testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module panel_tb -f panel.f -o panel_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/panel_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q -F '*** TEST PASSED ***'; then
	exit 0
fi
echo "pass message not found"
exit 1
